//--- src/nand_pkg.sv
// ****************************************
// shared NAND types and command codes; no address cycles,
// so only commands that need no address appear here
// ****************************************
package nand_pkg;

    // one byte on the NAND data bus, also used for commands and status
    typedef logic [7:0] nand_byte_t;

    // bus operation requested from the phase engine
    typedef enum logic {
        // latch one command byte with cle high
        OP_CMD  = 1'b0,
        // read one data byte with an re strobe
        OP_READ = 1'b1
    } nand_op_t;

    // reset aborts any operation inside the device
    localparam nand_byte_t CMD_RESET       = 8'hFF;

    // read status returns the status register on the next data read
    localparam nand_byte_t CMD_READ_STATUS = 8'h70;

    // status register bits, as the usual ONFI layout defines them
    //   bit 0  fail of the last program or erase
    //   bit 5  array ready
    //   bit 6  interface ready
    //   bit 7  write protect off
    // the design only passes the byte through, it never decodes it

    // level driven on the bus while nothing is being written
    localparam nand_byte_t BUS_IDLE        = 8'hFF;

endpackage : nand_pkg

//--- src/nand_bus_phy.sv
// ****************************************
// one command or read cycle per op_start, three phases of PHASE_CYCLES;
// op_start is ignored while a cycle is running
// ****************************************
module nand_bus_phy import nand_pkg::*; #(
    parameter int PHASE_CYCLES = 4
) (
    input  logic       clk,
    input  logic       rst_n,

    // operation request from the sequencer
    input  logic       op_start,
    input  nand_op_t   op_kind,
    input  nand_byte_t op_cmd,
    output logic       op_done,
    output nand_byte_t rd_data,

    // NAND pins, ce/we/re active low
    input  nand_byte_t nand_din,
    output nand_byte_t nand_dout,
    output logic       nand_oe,
    output logic       ce,
    output logic       we,
    output logic       re,
    output logic       cle
);

    localparam int CW = (PHASE_CYCLES > 1) ? $clog2(PHASE_CYCLES) : 1;
    localparam logic [CW-1:0] LAST_CYC = CW'(PHASE_CYCLES - 1);

    // setup drives the bus, strobe toggles we or re, release frees the pins
    typedef enum logic [1:0] {
        PH_SETUP   = 2'd0,
        PH_STROBE  = 2'd1,
        PH_RELEASE = 2'd2
    } phase_t;

    logic          active;
    phase_t        phase;
    logic [CW-1:0] cyc;
    nand_op_t      kind_q;
    logic          last_cyc;

    assign last_cyc = active && (cyc == LAST_CYC);

    // last cycle of the release phase closes the operation
    assign op_done = last_cyc && (phase == PH_RELEASE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active    <= 1'b0;
            phase     <= PH_SETUP;
            cyc       <= '0;
            kind_q    <= OP_CMD;
            ce        <= 1'b1;
            we        <= 1'b1;
            re        <= 1'b1;
            cle       <= 1'b0;
            nand_oe   <= 1'b0;
            nand_dout <= BUS_IDLE;
        end else if (!active) begin
            if (op_start) begin
                active <= 1'b1;
                phase  <= PH_SETUP;
                cyc    <= '0;
                kind_q <= op_kind;
                ce     <= 1'b0;
                if (op_kind == OP_CMD) begin
                    // command setup: cle, we low and the code on the bus
                    cle       <= 1'b1;
                    we        <= 1'b0;
                    nand_oe   <= 1'b1;
                    nand_dout <= op_cmd;
                end
            end
        end else if (cyc == LAST_CYC) begin
            cyc <= '0;
            case (phase)
                PH_SETUP: begin
                    phase <= PH_STROBE;
                    if (kind_q == OP_CMD) begin
                        // rising we latches the command
                        we <= 1'b1;
                    end else begin
                        re <= 1'b0;
                    end
                end
                PH_STROBE: begin
                    // release everything, bus back to input
                    phase     <= PH_RELEASE;
                    ce        <= 1'b1;
                    we        <= 1'b1;
                    re        <= 1'b1;
                    cle       <= 1'b0;
                    nand_oe   <= 1'b0;
                    nand_dout <= BUS_IDLE;
                end
                default: begin
                    active <= 1'b0;
                    phase  <= PH_SETUP;
                end
            endcase
        end else begin
            cyc <= cyc + 1'b1;
        end
    end

    // sample din at the end of the re low phase, before re rises
    always_ff @(posedge clk) begin
        if (last_cyc && (phase == PH_STROBE) && (kind_q == OP_READ)) begin
            rd_data <= nand_din;
        end
    end

    // a command latch and a data read must never overlap
    assert property (@(posedge clk) disable iff (!rst_n) !(cle && !re))
        else $error("nand_bus_phy: cle and re active together");

    // the bus is driven only with the chip selected
    assert property (@(posedge clk) disable iff (!rst_n) !(nand_oe && ce))
        else $error("nand_bus_phy: nand_oe high while ce is high");

endmodule : nand_bus_phy

//--- src/nand_status_seq.sv
// ****************************************
// one status poll per accepted start; start is ignored while busy
// ****************************************
module nand_status_seq import nand_pkg::*; #(
    parameter int RESET_WAIT_CYCLES = 32
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,

    // bus engine side
    output logic       op_start,
    output nand_op_t   op_kind,
    output nand_byte_t op_cmd,
    input  logic       op_done,
    input  nand_byte_t rd_data,

    // report side
    output nand_byte_t status,
    output logic       status_valid,
    output logic       tx_start,
    output nand_byte_t tx_data,
    input  logic       tx_busy,
    output logic       busy
);

    localparam int WW = (RESET_WAIT_CYCLES > 1) ? $clog2(RESET_WAIT_CYCLES) : 1;
    localparam logic [WW-1:0] LAST_WAIT = WW'(RESET_WAIT_CYCLES - 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_RST_CMD,
        S_RST_WAIT,
        S_STAT_CMD,
        S_READ,
        S_REPORT,
        S_TX_WAIT
    } state_t;

    state_t        state;
    logic [WW-1:0] wait_cnt;
    logic          op_pending;

    // the request fields follow the state that issued op_start
    assign op_kind      = (state == S_READ) ? OP_READ : OP_CMD;
    assign op_cmd       = (state == S_RST_CMD) ? CMD_RESET : CMD_READ_STATUS;
    assign status_valid = (state == S_REPORT);
    assign tx_start     = (state == S_REPORT);
    assign tx_data      = status;
    assign busy         = (state != S_IDLE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            op_start <= 1'b0;
            wait_cnt <= '0;
        end else begin
            op_start <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state    <= S_RST_CMD;
                        op_start <= 1'b1;
                    end
                end
                S_RST_CMD: begin
                    if (op_done) begin
                        state    <= S_RST_WAIT;
                        wait_cnt <= '0;
                    end
                end
                S_RST_WAIT: begin
                    // device recovery after reset
                    if (wait_cnt == LAST_WAIT) begin
                        state    <= S_STAT_CMD;
                        op_start <= 1'b1;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                S_STAT_CMD: begin
                    if (op_done) begin
                        state    <= S_READ;
                        op_start <= 1'b1;
                    end
                end
                S_READ: begin
                    if (op_done) begin
                        state <= S_REPORT;
                    end
                end
                S_REPORT: state <= S_TX_WAIT;
                default: begin
                    if (!tx_busy) begin
                        state <= S_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == S_READ) && op_done) begin
            status <= rd_data;
        end
    end

    // operation outstanding between op_start and the engine's op_done
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            op_pending <= 1'b0;
        end else if (op_start) begin
            op_pending <= 1'b1;
        end else if (op_done) begin
            op_pending <= 1'b0;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) op_start |-> !op_pending)
        else $error("nand_status_seq: op_start while an operation is outstanding");

endmodule : nand_status_seq

//--- src/uart_tx.sv
// ****************************************
// 8N1 transmitter, LSB first; tx_start is ignored while tx_busy is high
// ****************************************
module uart_tx import nand_pkg::*; #(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       tx_start,
    input  nand_byte_t tx_data,
    output logic       tx,
    output logic       tx_busy
);

    localparam int TW = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
    localparam logic [TW-1:0] LAST_TICK = TW'(CLKS_PER_BIT - 1);

    // start bit, eight data bits, stop bit
    localparam logic [3:0] LAST_BIT = 4'd9;

    logic [TW-1:0] timer;
    logic [3:0]    bit_cnt;
    logic          bit_end;
    logic          load;

    // data bits still to send, stop bit on top
    logic [8:0]    shreg;

    assign load    = tx_start && !tx_busy;
    assign bit_end = tx_busy && (timer == LAST_TICK);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tx      <= 1'b1;
            tx_busy <= 1'b0;
            timer   <= '0;
            bit_cnt <= '0;
        end else if (load) begin
            // start bit goes out immediately
            tx      <= 1'b0;
            tx_busy <= 1'b1;
            timer   <= '0;
            bit_cnt <= '0;
        end else if (bit_end) begin
            timer <= '0;
            if (bit_cnt == LAST_BIT) begin
                // stop bit done, line stays high
                tx_busy <= 1'b0;
            end else begin
                tx      <= shreg[0];
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else if (tx_busy) begin
            timer <= timer + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            shreg <= {1'b1, tx_data};
        end else if (bit_end) begin
            shreg <= {1'b1, shreg[8:1]};
        end
    end

    // the sequencer waits for the frame to end before the next byte
    assert property (@(posedge clk) disable iff (!rst_n) tx_start |-> !tx_busy)
        else $error("uart_tx: tx_start while a frame is in progress");

endmodule : uart_tx

//--- src/nand_uart_top.sv
// ****************************************
// NAND status poll to UART; ale is not a port, tie it low on the board
// ****************************************
module nand_uart_top import nand_pkg::*; #(
    parameter int PHASE_CYCLES      = 4,
    parameter int RESET_WAIT_CYCLES = 32,
    parameter int CLKS_PER_BIT      = 8
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    input  nand_byte_t nand_din,
    output nand_byte_t nand_dout,
    output logic       nand_oe,
    output logic       ce,
    output logic       we,
    output logic       re,
    output logic       cle,
    output nand_byte_t status,
    output logic       status_valid,
    output logic       busy,
    output logic       tx
);

    logic       op_start;
    nand_op_t   op_kind;
    nand_byte_t op_cmd;
    logic       op_done;
    nand_byte_t rd_data;
    logic       tx_start;
    nand_byte_t tx_data;
    logic       tx_busy;

    nand_status_seq #(
        .RESET_WAIT_CYCLES(RESET_WAIT_CYCLES)
    ) nand_status_seq_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .op_start    (op_start),
        .op_kind     (op_kind),
        .op_cmd      (op_cmd),
        .op_done     (op_done),
        .rd_data     (rd_data),
        .status      (status),
        .status_valid(status_valid),
        .tx_start    (tx_start),
        .tx_data     (tx_data),
        .tx_busy     (tx_busy),
        .busy        (busy)
    );

    nand_bus_phy #(
        .PHASE_CYCLES(PHASE_CYCLES)
    ) nand_bus_phy_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .op_start (op_start),
        .op_kind  (op_kind),
        .op_cmd   (op_cmd),
        .op_done  (op_done),
        .rd_data  (rd_data),
        .nand_din (nand_din),
        .nand_dout(nand_dout),
        .nand_oe  (nand_oe),
        .ce       (ce),
        .we       (we),
        .re       (re),
        .cle      (cle)
    );

    uart_tx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) uart_tx_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .tx_start(tx_start),
        .tx_data (tx_data),
        .tx      (tx),
        .tx_busy (tx_busy)
    );

endmodule : nand_uart_top

//--- tb/tb_checker.sv
// ****************************************
// watches the NAND pins, status and serial line at the falling clock edge
// ****************************************
module tb_checker import nand_pkg::*; #(
    parameter int CLKS_PER_BIT = 8,
    parameter int NUM_POLLS    = 8,
    parameter int NUM_EXTRA    = 4
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    input  nand_byte_t nand_dout,
    input  logic       nand_oe,
    input  logic       ce,
    input  logic       we,
    input  logic       re,
    input  logic       cle,
    input  nand_byte_t status,
    input  logic       status_valid,
    input  logic       busy,
    input  logic       tx,
    input  nand_byte_t model_status,
    input  logic       run_done,
    output int         error_count,
    output int         frame_count,
    output int         accepted_count,
    output int         ignored_count,
    output logic       final_done
);

    timeunit 1ns;
    timeprecision 1ps;

    int         bus_errors;
    int         frame_errors;
    int         report_count;
    int         cmd_idx;
    int         reports_in_poll;
    logic       prev_we;
    logic       prev_busy;
    logic       idle_checked;

    // bytes reported on status_valid that still wait for their frame
    nand_byte_t exp_bytes [16];
    logic [3:0] wr_ptr;
    logic [3:0] rd_ptr;

    assign error_count = bus_errors + frame_errors;

    // 8N1 frame in send order with start low, data LSB first and stop high
    function automatic logic [9:0] expected_frame(input nand_byte_t data);
        return {1'b1, data, 1'b0};
    endfunction

    task automatic check_level(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("mismatch %s: got %h expected %h", name, got, want);
            bus_errors++;
        end
    endtask

    always @(negedge clk) begin : bus_watch
        nand_byte_t want_cmd;
        if (rst_n !== 1'b1) begin
            prev_we         = 1'b1;
            prev_busy       = 1'b0;
            idle_checked    = 1'b0;
            cmd_idx         = 0;
            reports_in_poll = 0;
            report_count    = 0;
            wr_ptr          = '0;
            accepted_count  = 0;
            ignored_count   = 0;
            bus_errors      = 0;
            final_done      = 1'b0;
        end else begin
            if (!idle_checked) begin
                // pin levels right after reset and before any start
                idle_checked = 1'b1;
                check_level("ce", ce, 1'b1);
                check_level("we", we, 1'b1);
                check_level("re", re, 1'b1);
                check_level("cle", cle, 1'b0);
                check_level("nand_oe", nand_oe, 1'b0);
                check_level("busy", busy, 1'b0);
                check_level("status_valid", status_valid, 1'b0);
                check_level("tx", tx, 1'b1);
                if (nand_dout !== 8'hFF) begin
                    $display("mismatch nand_dout: got %h expected %h", nand_dout, 8'hFF);
                    bus_errors++;
                end
            end
            if (start) begin
                if (busy) begin
                    ignored_count++;
                end else begin
                    accepted_count++;
                end
            end
            if (busy && !prev_busy) begin
                cmd_idx         = 0;
                reports_in_poll = 0;
            end
            if (cle && !re) begin
                $display("error: cle and re are active at the same time");
                bus_errors++;
            end
            if (cle && !nand_oe) begin
                $display("error: nand_oe is low during a command phase");
                bus_errors++;
            end
            if (we && !prev_we && !ce && cle) begin
                if (cmd_idx > 1) begin
                    $display("error: extra command %h latched during one poll", nand_dout);
                    bus_errors++;
                end else begin
                    want_cmd = (cmd_idx == 0) ? CMD_RESET : CMD_READ_STATUS;
                    if (nand_dout !== want_cmd) begin
                        $display("mismatch nand_dout: got %h expected %h", nand_dout, want_cmd);
                        bus_errors++;
                    end
                end
                cmd_idx++;
            end
            if (status_valid) begin
                if (status !== model_status) begin
                    $display("mismatch status: got %h expected %h", status, model_status);
                    bus_errors++;
                end
                exp_bytes[wr_ptr] = model_status;
                wr_ptr            = wr_ptr + 4'd1;
                report_count++;
                reports_in_poll++;
            end
            if (!busy && prev_busy) begin
                if (cmd_idx != 2) begin
                    $display("error: poll latched %0d commands instead of two", cmd_idx);
                    bus_errors++;
                end
                if (reports_in_poll != 1) begin
                    $display("error: poll gave %0d status reports instead of one",
                             reports_in_poll);
                    bus_errors++;
                end
            end
            if (run_done && !final_done) begin
                if ((accepted_count != NUM_POLLS) || (ignored_count != NUM_EXTRA)) begin
                    $display("error: %0d accepted and %0d ignored starts, expected %0d and %0d",
                             accepted_count, ignored_count, NUM_POLLS, NUM_EXTRA);
                    bus_errors++;
                end
                if (frame_count != accepted_count) begin
                    $display("error: %0d frames sent for %0d accepted starts",
                             frame_count, accepted_count);
                    bus_errors++;
                end
                if (report_count != accepted_count) begin
                    $display("error: %0d status reports for %0d accepted starts",
                             report_count, accepted_count);
                    bus_errors++;
                end
                final_done = 1'b1;
            end
            prev_we   = we;
            prev_busy = busy;
        end
    end

    initial begin : frame_rx
        logic       prev_tx;
        logic [9:0] got;
        logic [9:0] want;
        prev_tx      = 1'b1;
        got          = '0;
        frame_count  = 0;
        frame_errors = 0;
        rd_ptr       = '0;
        forever begin
            @(negedge clk);
            if (rst_n && prev_tx && !tx) begin
                // step from the falling edge of the start bit to its middle
                repeat (CLKS_PER_BIT / 2 - 1) @(negedge clk);
                for (int i = 0; i < 10; i++) begin
                    got = {tx, got[9:1]};
                    if (i < 9) begin
                        repeat (CLKS_PER_BIT) @(negedge clk);
                    end
                end
                if (frame_count >= report_count) begin
                    $display("error: serial frame %h sent without a status report", got);
                    frame_errors++;
                end else begin
                    want   = expected_frame(exp_bytes[rd_ptr]);
                    rd_ptr = rd_ptr + 4'd1;
                    if (got !== want) begin
                        $display("mismatch tx frame: got %h expected %h", got, want);
                        frame_errors++;
                    end
                end
                frame_count++;
            end
            prev_tx = tx;
        end
    end

endmodule : tb_checker

//--- tb/tb_top.sv
// ****************************************
// runs eight status polls and pulses an extra start while busy in every second one
// the NAND model answers read status only and picks a new random byte per reset
// ****************************************
module tb_top import nand_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int PHASE_CYCLES      = 4;
    localparam int RESET_WAIT_CYCLES = 32;
    localparam int CLKS_PER_BIT      = 8;
    localparam int NUM_POLLS         = 8;
    localparam int CLK_PERIOD_NS     = 4;

    // every odd poll carries one extra start
    localparam int NUM_EXTRA         = NUM_POLLS / 2;

    // three bus operations, recovery wait, one frame and a few cycles of handover
    localparam int POLL_CYCLES = 3 * 3 * PHASE_CYCLES + RESET_WAIT_CYCLES
                                 + 10 * CLKS_PER_BIT + 8;
    localparam int RUN_CYCLES  = 8 + 4 + NUM_POLLS * (POLL_CYCLES + 4);
    localparam int WATCHDOG_NS = 2 * RUN_CYCLES * CLK_PERIOD_NS + 200;

    logic       clk;
    logic       rst_n;
    logic       start;
    nand_byte_t nand_din;
    nand_byte_t nand_dout;
    logic       nand_oe;
    logic       ce;
    logic       we;
    logic       re;
    logic       cle;
    nand_byte_t status;
    logic       status_valid;
    logic       busy;
    logic       tx;

    logic       run_done;
    logic       final_done;
    int         error_count;
    int         frame_count;
    int         accepted_count;
    int         ignored_count;

    // NAND model state
    integer     seed = 32'h04d798e8;
    nand_byte_t model_status = 8'h00;
    nand_byte_t last_cmd = 8'h00;

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD_NS / 2) clk = ~clk;
    end

    nand_uart_top #(
        .PHASE_CYCLES     (PHASE_CYCLES),
        .RESET_WAIT_CYCLES(RESET_WAIT_CYCLES),
        .CLKS_PER_BIT     (CLKS_PER_BIT)
    ) nand_uart_top_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .nand_din    (nand_din),
        .nand_dout   (nand_dout),
        .nand_oe     (nand_oe),
        .ce          (ce),
        .we          (we),
        .re          (re),
        .cle         (cle),
        .status      (status),
        .status_valid(status_valid),
        .busy        (busy),
        .tx          (tx)
    );

    tb_checker #(
        .CLKS_PER_BIT(CLKS_PER_BIT),
        .NUM_POLLS   (NUM_POLLS),
        .NUM_EXTRA   (NUM_EXTRA)
    ) tb_checker_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .nand_dout     (nand_dout),
        .nand_oe       (nand_oe),
        .ce            (ce),
        .we            (we),
        .re            (re),
        .cle           (cle),
        .status        (status),
        .status_valid  (status_valid),
        .busy          (busy),
        .tx            (tx),
        .model_status  (model_status),
        .run_done      (run_done),
        .error_count   (error_count),
        .frame_count   (frame_count),
        .accepted_count(accepted_count),
        .ignored_count (ignored_count),
        .final_done    (final_done)
    );

    // command latch on the rising edge of we with the chip selected and cle high
    always @(posedge we) begin
        if (!ce && cle) begin
            last_cmd = nand_dout;
            if (nand_dout == CMD_RESET) begin
                model_status = 8'($random(seed));
            end
        end
    end

    // status register on the bus while re and ce are low after read status
    assign nand_din = (!ce && !re && (last_cmd == CMD_READ_STATUS)) ? model_status : 8'h00;

    task automatic pulse_start();
        @(posedge clk);
        #1 start = 1'b1;
        @(posedge clk);
        #1 start = 1'b0;
    endtask

    task automatic run_poll(input logic extra, input int gap);
        pulse_start();
        if (extra) begin
            // second strobe lands while the poll is still running
            repeat (gap) @(posedge clk);
            pulse_start();
        end
        while (busy) @(negedge clk);
        repeat (3) @(posedge clk);
    endtask

    initial begin : main
        rst_n    = 1'b0;
        start    = 1'b0;
        run_done = 1'b0;
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;
        repeat (4) @(posedge clk);
        for (int p = 0; p < NUM_POLLS; p++) begin
            run_poll(p % 2 == 1, 4 + 15 * p);
        end
        @(posedge clk);
        #1 run_done = 1'b1;
        while (!final_done) @(negedge clk);
        $display("errors %0d, accepted starts %0d, ignored starts %0d, frames %0d",
                 error_count, accepted_count, ignored_count, frame_count);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("error: watchdog expired after %0d ns, the polls did not complete",
                 WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

endmodule : tb_top

//--- all.f
src/nand_pkg.sv
src/nand_bus_phy.sv
src/nand_status_seq.sv
src/uart_tx.sv
src/nand_uart_top.sv
tb/tb_checker.sv
tb/tb_top.sv

//--- run.sh
#!/bin/sh
# build and run the NAND status poll testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_top --Mdir obj_dir -f all.f > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/Vtb_top > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" "$SIM_LOG"; then
    exit 1
fi
exit 0
